//--- codec_seq/codec_reg_sequencer.sv
`timescale 1ns/1ps

module codec_reg_sequencer #(
  parameter logic [6:0] CODEC_I2C_ADDR = 7'h1A
) (
  input  logic                       clk,
  input  logic                       reset,
  input  codec_ctrl_pkg::codec_req_t req,
  output logic [7:0]                 rdata,
  output logic                       rdata_valid,
  output logic                       error,
  output logic                       busy,
  output codec_ctrl_pkg::reg_req_t   bus_req,
  input  codec_ctrl_pkg::reg_rsp_t   bus_rsp
);
  import codec_ctrl_pkg::*;

  seq_state_e state;
  seq_state_e after_ack;    // Next state once a write is done
  logic [7:0] int_addr;     // CODEC register index
  logic [7:0] wdata;
  logic       is_rd;
  logic       rd_phase;     // Address phase of a read is over
  logic       xfer_started; // Busy 0 -> 1 seen
  logic [7:0] sts;          // Last status value
  logic [3:0] rd_addr;      // Target of the next register read
  logic [7:0] cmd_word;

  // Write: START|WRITE|STOP, read: START|WRITE then START|READ|STOP
  always_comb begin
    cmd_word                = '0;
    cmd_word[CMD_START_BIT] = 1'b1;
    cmd_word[CMD_WRITE_BIT] = !(is_rd && rd_phase);
    cmd_word[CMD_READ_BIT]  = is_rd && rd_phase;
    cmd_word[CMD_STOP_BIT]  = !is_rd || rd_phase;
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state        <= SEQ_IDLE;
      after_ack    <= SEQ_IDLE;
      int_addr     <= '0;
      wdata        <= '0;
      is_rd        <= 1'b0;
      rd_phase     <= 1'b0;
      xfer_started <= 1'b0;
      sts          <= '0;
      rd_addr      <= REG_STATUS;
      rdata        <= '0;
      rdata_valid  <= 1'b0;
      error        <= 1'b0;
      busy         <= 1'b0;
      bus_req      <= '0;
    end else begin
      bus_req.read  <= 1'b0; // Strobes last one cycle
      bus_req.write <= 1'b0;
      rdata_valid   <= 1'b0;
      error         <= 1'b0;

      case (state)
        SEQ_IDLE: begin
          if (req.wr_en || req.rd_en) begin // Only taken while not busy
            int_addr     <= req.reg_addr;
            wdata        <= req.wdata;
            is_rd        <= !req.wr_en;     // Write wins
            rd_phase     <= 1'b0;
            busy         <= 1'b1;
            state        <= SEQ_WR_DEV_ADDR;
          end
        end

        SEQ_WR_DEV_ADDR: begin
          bus_req.write <= 1'b1;
          bus_req.addr  <= REG_ADDR;
          bus_req.wdata <= {1'b0, CODEC_I2C_ADDR};
          after_ack     <= SEQ_WR_INT_ADDR;
          state         <= SEQ_WAIT_ACK;
        end

        SEQ_WR_INT_ADDR: begin // First queued byte
          bus_req.write <= 1'b1;
          bus_req.addr  <= REG_DATA;
          bus_req.wdata <= int_addr;
          after_ack     <= is_rd ? SEQ_WR_CMD : SEQ_WR_DATA;
          state         <= SEQ_WAIT_ACK;
        end

        SEQ_WR_DATA: begin
          bus_req.write <= 1'b1;
          bus_req.addr  <= REG_DATA;
          bus_req.wdata <= wdata;
          after_ack     <= SEQ_WR_CMD;
          state         <= SEQ_WAIT_ACK;
        end

        SEQ_WR_CMD: begin
          bus_req.write <= 1'b1;
          bus_req.addr  <= REG_CMD;
          bus_req.wdata <= cmd_word;
          xfer_started  <= 1'b0;
          sts           <= '0; // Forget the previous poll
          after_ack     <= SEQ_POLL_DONE;
          state         <= SEQ_WAIT_ACK;
        end

        SEQ_WAIT_ACK: if (bus_rsp.done) state <= after_ack;

        SEQ_READ_REG: begin
          bus_req.read <= 1'b1;
          bus_req.addr <= rd_addr;
          state        <= SEQ_WAIT_RD_ACK;
        end

        SEQ_WAIT_RD_ACK: begin
          if (bus_rsp.done && bus_rsp.rdata_valid) begin
            if (rd_addr == REG_DATA) begin // Final byte of a read
              rdata       <= bus_rsp.rdata;
              rdata_valid <= 1'b1;
              busy        <= 1'b0;
              state       <= SEQ_IDLE;
            end else begin
              sts   <= bus_rsp.rdata;
              state <= SEQ_POLL_DONE;
            end
          end
        end

        SEQ_POLL_DONE: begin
          // Keep polling until busy has gone 0 -> 1 -> 0
          if (!xfer_started || sts[STS_BUSY_BIT]) begin
            if (sts[STS_BUSY_BIT]) xfer_started <= 1'b1;
            rd_addr <= REG_STATUS;
            state   <= SEQ_READ_REG;
          end else if (sts[STS_NACK_BIT]) begin // Device refused, give up
            error <= 1'b1;
            busy  <= 1'b0;
            state <= SEQ_IDLE;
          end else if (is_rd && !rd_phase) begin
            rd_phase <= 1'b1;            // Now the data phase
            state    <= SEQ_WR_CMD;
          end else if (is_rd) begin
            state <= SEQ_GET_RD_DATA;
          end else begin
            busy  <= 1'b0;               // Write finished
            state <= SEQ_IDLE;
          end
        end

        SEQ_GET_RD_DATA: begin
          rd_addr <= REG_DATA;
          state   <= SEQ_READ_REG;
        end

        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // One access type per strobe cycle
  assert property (@(posedge clk) disable iff (!reset) !(bus_req.read && bus_req.write))
    else $error("bus_req read and write high together");

endmodule

//--- common/codec_ctrl_pkg.sv
package codec_ctrl_pkg;

  //////////////////////////////
  // Host and register bus
  //////////////////////////////

  typedef struct packed {
    logic       rd_en;    // Read one CODEC register
    logic       wr_en;    // Write one CODEC register, wins over rd_en
    logic [7:0] reg_addr; // CODEC register index
    logic [7:0] wdata;    // Write payload
  } codec_req_t;

  typedef struct packed {
    logic       read;  // 1-cycle strobe
    logic       write; // 1-cycle strobe
    logic [3:0] addr;
    logic [7:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [7:0] rdata;
    logic       rdata_valid; // Comes with done on reads
    logic       done;        // One cycle after the strobe
  } reg_rsp_t;

  // I2C master register map
  typedef enum logic [3:0] {
    REG_STATUS = 4'd0,
    REG_ADDR   = 4'd2,
    REG_CMD    = 4'd3,
    REG_DATA   = 4'd4
  } reg_addr_e;

  localparam int STS_BUSY_BIT = 0;
  localparam int STS_NACK_BIT = 1;

  // Command word bits
  localparam int CMD_START_BIT = 0;
  localparam int CMD_READ_BIT  = 1;
  localparam int CMD_WRITE_BIT = 2;
  localparam int CMD_STOP_BIT  = 3;
  localparam int CMD_CNT_LSB   = 4; // Queued byte count, [5:4] of eng_cmd

  //////////////////////////////
  // State machines
  //////////////////////////////

  typedef enum logic [3:0] {
    SEQ_IDLE, SEQ_WR_DEV_ADDR, SEQ_WR_INT_ADDR, SEQ_WR_DATA, SEQ_WR_CMD,
    SEQ_WAIT_ACK, SEQ_READ_REG, SEQ_WAIT_RD_ACK, SEQ_POLL_DONE, SEQ_GET_RD_DATA
  } seq_state_e;

  typedef enum logic [3:0] {
    ENG_IDLE, ENG_START, ENG_BIT_LOW, ENG_BIT_HIGH,
    ENG_ACK_LOW, ENG_ACK_HIGH, ENG_STOP, ENG_DONE
  } eng_state_e;

endpackage

//--- design/codec_ctrl_top.sv
`timescale 1ns/1ps

module codec_ctrl_top #(
  parameter logic [6:0] CODEC_I2C_ADDR = 7'h1A,
  parameter int         SCL_QUARTER    = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  codec_ctrl_pkg::codec_req_t req,
  output logic [7:0]                 codec_rdata,
  output logic                       codec_rdata_valid,
  output logic                       codec_error,
  output logic                       busy,
  output logic                       scl,
  output logic                       sda_oe,
  input  logic                       sda_in
);
  import codec_ctrl_pkg::*;

  reg_req_t   bus_req;
  reg_rsp_t   bus_rsp;
  logic       eng_go;
  logic [7:0] eng_cmd;
  logic [6:0] dev_addr;
  logic [7:0] tx_byte;
  logic       tx_pop;
  logic       eng_busy;
  logic       eng_nack;
  logic [7:0] rx_byte;
  logic       eng_done;

  // Host request to register accesses
  codec_reg_sequencer #(
    .CODEC_I2C_ADDR(CODEC_I2C_ADDR)
  ) seq_i (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .rdata       (codec_rdata),
    .rdata_valid (codec_rdata_valid),
    .error       (codec_error),
    .busy        (busy),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp)
  );

  i2c_master_regs regs_i (
    .clk      (clk),
    .reset    (reset),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .eng_go   (eng_go),
    .eng_cmd  (eng_cmd),
    .dev_addr (dev_addr),
    .tx_byte  (tx_byte),
    .tx_pop   (tx_pop),
    .eng_busy (eng_busy),
    .eng_nack (eng_nack),
    .rx_byte  (rx_byte),
    .eng_done (eng_done)
  );

  // SCL/SDA timing
  i2c_byte_engine #(
    .SCL_QUARTER(SCL_QUARTER)
  ) eng_i (
    .clk      (clk),
    .reset    (reset),
    .go       (eng_go),
    .cmd      (eng_cmd),
    .dev_addr (dev_addr),
    .tx_byte  (tx_byte),
    .tx_pop   (tx_pop),
    .busy     (eng_busy),
    .nack     (eng_nack),
    .rx_byte  (rx_byte),
    .done     (eng_done),
    .scl      (scl),
    .sda_oe   (sda_oe),
    .sda_in   (sda_in)
  );

endmodule

//--- i2c_master/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine #(
  parameter int SCL_QUARTER = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       go,
  input  logic [7:0] cmd,
  input  logic [6:0] dev_addr,
  input  logic [7:0] tx_byte,
  output logic       tx_pop,
  output logic       busy,
  output logic       nack,
  output logic [7:0] rx_byte,
  output logic       done,
  output logic       scl,
  output logic       sda_oe,
  input  logic       sda_in
);
  import codec_ctrl_pkg::*;

  localparam int CW = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;

  eng_state_e    state;
  logic [CW-1:0] qcnt;      // Cycles within a quarter
  logic [1:0]    qtr;       // Quarter within the state
  logic          tick;
  logic          last_q;
  logic [7:0]    cmd_q;
  logic [7:0]    shreg;     // Shifts out on tx, in on rx
  logic [2:0]    bit_cnt;
  logic [1:0]    tx_left;   // Queued bytes still to send
  logic          addr_byte;
  logic          rd_byte;
  logic          scl_d;
  logic          sda_d;

  assign busy   = (state != ENG_IDLE);
  assign done   = (state == ENG_DONE);
  assign tick   = (qcnt == CW'(SCL_QUARTER - 1));
  // START and STOP take four quarters, the others two
  assign last_q = tick &&
                  (qtr == ((state == ENG_START || state == ENG_STOP) ? 2'd3 : 2'd1));

  //////////////////////////////
  // Line levels per quarter
  //////////////////////////////
  always_comb begin
    scl_d = scl;
    sda_d = sda_oe;
    case (state)
      ENG_START: begin
        scl_d = qtr[0] ^ qtr[1]; // High in quarters 1 and 2
        sda_d = qtr[1];          // SDA falls with SCL high
      end
      ENG_BIT_LOW: begin
        scl_d = 1'b0;
        if (qtr != 2'd0) sda_d = !rd_byte && !shreg[7]; // Data moves after SCL is low
      end
      ENG_BIT_HIGH, ENG_ACK_HIGH: scl_d = 1'b1;
      ENG_ACK_LOW: begin
        scl_d = 1'b0;
        if (qtr != 2'd0) sda_d = 1'b0; // Release for ACK, or NACK on reads
      end
      ENG_STOP: begin
        scl_d = qtr[1];
        if (qtr != 2'd0) sda_d = (qtr != 2'd3); // SDA rises with SCL high
      end
      ENG_DONE: scl_d = scl && (cmd_q[CMD_STOP_BIT] || nack); // Park low for repeated START
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      scl    <= 1'b1;
      sda_oe <= 1'b0;
    end else begin
      scl    <= scl_d;
      sda_oe <= sda_d;
    end
  end

  //////////////////////////////
  // Sequencing
  //////////////////////////////
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state     <= ENG_IDLE;
      qcnt      <= '0;
      qtr       <= '0;
      cmd_q     <= '0;
      shreg     <= '0;
      bit_cnt   <= '0;
      tx_left   <= '0;
      addr_byte <= 1'b0;
      rd_byte   <= 1'b0;
      nack      <= 1'b0;
      rx_byte   <= '0;
      tx_pop    <= 1'b0;
    end else begin
      tx_pop <= 1'b0;
      qcnt   <= (tick || !busy || done) ? '0 : qcnt + 1'b1;
      if (tick) qtr <= qtr + 2'd1;

      case (state)
        ENG_IDLE: begin
          if (go) begin
            cmd_q     <= cmd;
            tx_left   <= cmd[CMD_CNT_LSB +: 2];
            shreg     <= {dev_addr, cmd[CMD_READ_BIT]}; // R/W from the command
            bit_cnt   <= 3'd7;
            addr_byte <= 1'b1;
            rd_byte   <= 1'b0;
            nack      <= 1'b0;
            qtr       <= scl ? 2'd1 : 2'd0; // SCL already high, skip a quarter
            state     <= cmd[CMD_START_BIT] ? ENG_START : ENG_DONE;
          end
        end

        ENG_START: begin
          if (last_q) begin
            qtr   <= '0;
            state <= ENG_BIT_LOW;
          end
        end

        ENG_BIT_LOW: begin
          if (last_q) begin
            qtr   <= '0;
            state <= ENG_BIT_HIGH;
          end
        end

        ENG_BIT_HIGH: begin
          if (tick && qtr == 2'd0) begin // Sample mid SCL high
            shreg <= {shreg[6:0], sda_in};
            if (rd_byte && bit_cnt == 3'd0) rx_byte <= {shreg[6:0], sda_in};
          end
          if (last_q) begin
            qtr     <= '0;
            bit_cnt <= bit_cnt - 3'd1;
            state   <= (bit_cnt == 3'd0) ? ENG_ACK_LOW : ENG_BIT_LOW;
          end
        end

        ENG_ACK_LOW: begin
          if (last_q) begin
            qtr   <= '0;
            state <= ENG_ACK_HIGH;
          end
        end

        ENG_ACK_HIGH: begin
          if (tick && qtr == 2'd0 && !rd_byte && sda_in) nack <= 1'b1; // Device NACK
          if (last_q) begin
            qtr       <= '0;
            bit_cnt   <= 3'd7;
            addr_byte <= 1'b0;
            if (nack) begin
              state <= ENG_STOP;                  // Abort at once
            end else if (addr_byte && cmd_q[CMD_READ_BIT]) begin
              rd_byte <= 1'b1;                    // One byte in
              state   <= ENG_BIT_LOW;
            end else if (!rd_byte && cmd_q[CMD_WRITE_BIT] && tx_left != 2'd0) begin
              shreg   <= tx_byte;
              tx_pop  <= 1'b1;
              tx_left <= tx_left - 2'd1;
              state   <= ENG_BIT_LOW;
            end else begin
              state <= cmd_q[CMD_STOP_BIT] ? ENG_STOP : ENG_DONE;
            end
          end
        end

        ENG_STOP: begin
          if (last_q) state <= ENG_DONE;
        end

        ENG_DONE: state <= ENG_IDLE;   // done pulse

        default: state <= ENG_IDLE;
      endcase
    end
  end

  // SDA moves under a low SCL except for START and STOP
  assert property (@(posedge clk) disable iff (!reset)
    $changed(sda_oe) |-> (!scl && !$past(scl)) || $past(state) inside {ENG_START, ENG_STOP})
    else $error("SDA changed while SCL high outside START/STOP");

endmodule

//--- i2c_master/i2c_master_regs.sv
`timescale 1ns/1ps

module i2c_master_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  codec_ctrl_pkg::reg_req_t bus_req,
  output codec_ctrl_pkg::reg_rsp_t bus_rsp,
  output logic                     eng_go,
  output logic [7:0]               eng_cmd,
  output logic [6:0]               dev_addr,
  output logic [7:0]               tx_byte,
  input  logic                     tx_pop,
  input  logic                     eng_busy,
  input  logic                     eng_nack,
  input  logic [7:0]               rx_byte,
  input  logic                     eng_done
);
  import codec_ctrl_pkg::*;

  logic [7:0] cmd_q;
  logic       busy_q;
  logic       nack_q;   // Held until the next command
  logic [7:0] q_mem [2]; // Transmit queue
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] q_cnt;
  logic       push_req;
  logic       push;
  logic       cmd_wr;
  logic [7:0] rd_mux;

  assign push_req = bus_req.write && (bus_req.addr == REG_DATA);
  assign push     = push_req && (q_cnt != 2'd2); // Drop on overflow
  assign cmd_wr   = bus_req.write && (bus_req.addr == REG_CMD);
  assign tx_byte  = q_mem[rd_ptr];

  // Engine sees the queue depth next to the command bits
  always_comb begin
    eng_cmd                    = cmd_q;
    eng_cmd[CMD_CNT_LSB +: 2] = q_cnt;
  end

  always_comb begin
    rd_mux = '0;
    case (bus_req.addr)
      REG_STATUS: begin
        rd_mux[STS_BUSY_BIT] = busy_q;
        rd_mux[STS_NACK_BIT] = nack_q;
      end
      REG_ADDR: rd_mux = {1'b0, dev_addr};
      REG_CMD:  rd_mux = cmd_q;
      REG_DATA: rd_mux = rx_byte;     // Receive side
      default:  rd_mux = '0;
    endcase
  end

  // Response one cycle after the strobe
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      bus_rsp <= '0;
    end else begin
      bus_rsp.done        <= bus_req.read || bus_req.write;
      bus_rsp.rdata_valid <= bus_req.read;
      bus_rsp.rdata       <= rd_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (push) q_mem[wr_ptr] <= bus_req.wdata;
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      eng_go   <= 1'b0;
      busy_q   <= 1'b0;
      nack_q   <= 1'b0;
      dev_addr <= '0;
      cmd_q    <= '0;
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
      q_cnt    <= '0;
    end else begin
      eng_go <= cmd_wr && !eng_busy; // No launch into a running transfer
      if (bus_req.write && bus_req.addr == REG_ADDR) dev_addr <= bus_req.wdata[6:0];
      if (cmd_wr) begin
        cmd_q  <= bus_req.wdata;
        busy_q <= !eng_busy;
        nack_q <= 1'b0;
      end else if (eng_done) begin
        busy_q <= 1'b0;   // Status busy falls a cycle after done
        nack_q <= eng_nack;
      end
      // Leftover bytes after a NACK are flushed at done
      if (eng_done) begin
        wr_ptr <= 1'b0;
        rd_ptr <= 1'b0;
        q_cnt  <= '0;
      end else begin
        if (push) wr_ptr <= !wr_ptr;
        if (tx_pop) rd_ptr <= !rd_ptr;
        q_cnt <= q_cnt + {1'b0, push} - {1'b0, tx_pop};
      end
    end
  end

  // Sequencer never writes more than the queue holds
  assert property (@(posedge clk) disable iff (!reset) push_req |-> q_cnt != 2'd2)
    else $error("Transmit queue pushed while full");

endmodule

//--- src.f
common/codec_ctrl_pkg.sv
codec_seq/codec_reg_sequencer.sv
i2c_master/i2c_master_regs.sv
i2c_master/i2c_byte_engine.sv
design/codec_ctrl_top.sv
test/i2c_codec_model.sv
test/codec_ctrl_tb.sv

//--- test/codec_ctrl_tb.sv
`timescale 1ns/1ps

module codec_ctrl_tb;
  import codec_ctrl_pkg::*;

  localparam logic [6:0] CODEC_I2C_ADDR = 7'h1A;
  localparam int SCL_QUARTER = 4;
  localparam int CLK_PERIOD  = 20;
  localparam int N_WR        = 20;
  localparam int N_RD        = 20;
  localparam int N_BUSY      = 4;
  localparam int N_TRANS     = N_WR + N_RD + 2 * N_BUSY + 3;
  // 40 SCL periods per transaction, slack for reset and polling
  localparam int TIMEOUT_NS  = N_TRANS * 40 * 4 * SCL_QUARTER * CLK_PERIOD + 100_000;

  logic       clk = 1'b0;
  logic       reset;
  codec_req_t req;
  logic [7:0] codec_rdata;
  logic       codec_rdata_valid;
  logic       codec_error;
  logic       busy;
  logic       scl;
  logic       sda_oe;
  logic       slave_pull;
  logic       nack_all;
  logic       sda;

  integer     seed;
  int         checks    = 0;
  int         errors    = 0;
  int         valid_cnt = 0;    // codec_rdata_valid pulses seen
  int         error_cnt = 0;    // codec_error pulses seen
  logic [7:0] last_rdata = '0;
  logic [7:0] ref_mem [256];    // Expected CODEC registers
  logic [7:0] inj_addr = '0;    // Address of the last request sent while busy

  assign sda = !(sda_oe || slave_pull); // Pull-up unless someone pulls low

  always #(CLK_PERIOD / 2) clk = ~clk;

  codec_ctrl_top #(
    .CODEC_I2C_ADDR(CODEC_I2C_ADDR),
    .SCL_QUARTER   (SCL_QUARTER)
  ) dut_i (
    .clk               (clk),
    .reset             (reset),
    .req               (req),
    .codec_rdata       (codec_rdata),
    .codec_rdata_valid (codec_rdata_valid),
    .codec_error       (codec_error),
    .busy              (busy),
    .scl               (scl),
    .sda_oe            (sda_oe),
    .sda_in            (sda)
  );

  i2c_codec_model #(
    .DEV_ADDR(CODEC_I2C_ADDR)
  ) model_i (
    .scl      (scl),
    .sda      (sda),
    .nack_all (nack_all),
    .sda_pull (slave_pull)
  );

  // Pulses are a full cycle wide, so one look per falling edge
  always @(negedge clk) begin
    if (codec_rdata_valid) begin
      valid_cnt  <= valid_cnt + 1;
      last_rdata <= codec_rdata;
    end
    if (codec_error) error_cnt <= error_cnt + 1;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  task automatic match_model_mem();
    for (int i = 0; i < 256; i++) begin
      compare($sformatf("model mem[%0d]", i), model_i.mem[i], ref_mem[i]);
    end
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  //////////////////////////////
  // Host side
  //////////////////////////////
  // Called on a falling edge, holds the request for one cycle
  task automatic pulse_request(input logic rd, input logic wr,
                               input logic [7:0] addr, input logic [7:0] data);
    req.rd_en    = rd;
    req.wr_en    = wr;
    req.reg_addr = addr;
    req.wdata    = data;
    @(negedge clk);
    req = '0;
  endtask

  task automatic wait_idle(input bit inject);
    logic [31:0] r;
    if (inject) begin
      r = $random(seed);
      repeat (1 + r[5:0]) @(negedge clk);
      require(busy, "transfer ended before the extra request could be sent");
      if (busy) begin
        inj_addr = r[15:8];
        pulse_request(r[16], r[17] || !r[16], r[15:8], r[23:16]); // Should be ignored
      end
    end
    while (busy) @(negedge clk);  // Watchdog covers a hang
    @(negedge clk);               // Let the pulse counters catch up
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data,
                           input bit expect_nack, input bit inject);
    int v0;
    int e0;
    v0 = valid_cnt;
    e0 = error_cnt;
    pulse_request(1'b0, 1'b1, addr, data);
    require(busy, "write request was not accepted");
    wait_idle(inject);
    compare("codec_error pulses", error_cnt - e0, expect_nack);
    compare("codec_rdata_valid pulses", valid_cnt - v0, 0);
    if (!expect_nack) ref_mem[addr] = data;
  endtask

  task automatic read_reg(input logic [7:0] addr, input bit expect_nack, input bit inject);
    int v0;
    int e0;
    v0 = valid_cnt;
    e0 = error_cnt;
    pulse_request(1'b1, 1'b0, addr, 8'h00);
    require(busy, "read request was not accepted");
    wait_idle(inject);
    compare("codec_error pulses", error_cnt - e0, expect_nack);
    compare("codec_rdata_valid pulses", valid_cnt - v0, !expect_nack);
    if (!expect_nack) compare("codec_rdata", last_rdata, ref_mem[addr]);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int          c0;
    int          e0;
    logic [31:0] r;
    seed     = 32'h5c530cdb;
    reset    = 1'b0;
    req      = '0;
    nack_all = 1'b0;
    for (int i = 0; i < 256; i++) ref_mem[i] = 8'(i) ^ 8'hA5; // Power-up contents

    repeat (8) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);

    c0 = checks;
    e0 = errors;
    compare("busy", busy, 1'b0);
    compare("codec_rdata_valid", codec_rdata_valid, 1'b0);
    compare("codec_error", codec_error, 1'b0);
    compare("scl", scl, 1'b1);
    compare("sda_oe", sda_oe, 1'b0);
    report_test("after reset", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_WR; i++) begin
      r = $random(seed);
      write_reg(r[7:0], r[15:8], 1'b0, 1'b0);
    end
    match_model_mem();
    report_test("random writes", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_RD; i++) begin
      r = $random(seed);
      read_reg(r[7:0], 1'b0, 1'b0);
    end
    report_test("random reads", c0, e0);

    // Extra requests while busy, alternating write and read
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_BUSY; i++) begin
      r = $random(seed);
      if (i % 2 == 0) write_reg(r[7:0], r[15:8], 1'b0, 1'b1);
      else read_reg(r[7:0], 1'b0, 1'b1);
      match_model_mem();
      read_reg(inj_addr, 1'b0, 1'b0);
    end
    report_test("requests while busy", c0, e0);

    c0 = checks;
    e0 = errors;
    nack_all = 1'b1;
    r = $random(seed);
    read_reg(r[7:0], 1'b1, 1'b0);
    r = $random(seed);
    write_reg(r[7:0], r[15:8], 1'b1, 1'b0);
    match_model_mem();
    nack_all = 1'b0;
    r = $random(seed);
    read_reg(r[7:0], 1'b0, 1'b0);
    report_test("device nack", c0, e0);

    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns with a transfer still open", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- test/i2c_codec_model.sv
`timescale 1ns/1ps

module i2c_codec_model #(
  parameter logic [6:0] DEV_ADDR = 7'h1A
) (
  input  logic scl,
  input  logic sda,       // Resolved line
  input  logic nack_all,  // NACK every byte while high
  output logic sda_pull   // 1 pulls SDA low
);

  typedef enum logic [2:0] {
    M_IDLE, M_ADDR, M_REG, M_WDATA, M_RDATA
  } slave_state_e;

  logic [7:0]   mem [256];        // CODEC register array
  slave_state_e mstate   = M_IDLE;
  logic [7:0]   shreg    = '0;    // Incoming byte
  logic [7:0]   tx       = '0;    // Outgoing byte on reads
  logic [7:0]   ptr      = '0;    // Register pointer, set by the first written byte
  int           bit_cnt  = 0;
  logic         ack_slot = 1'b0;  // Ninth clock of a byte
  logic         scl_prev = 1'b1;
  logic         sda_prev = 1'b1;

  initial begin
    sda_pull = 1'b0;
    for (int i = 0; i < 256; i++) mem[i] = 8'(i) ^ 8'hA5;
  end

  //////////////////////////////
  // Bus events
  //////////////////////////////
  always @(scl or sda) begin
    if (scl_prev && scl && sda_prev && !sda) begin
      // START or repeated START
      mstate   = M_ADDR;
      bit_cnt  = 0;
      ack_slot = 1'b0;
      sda_pull = 1'b0;
    end else if (scl_prev && scl && !sda_prev && sda) begin
      mstate   = M_IDLE;    // STOP
      ack_slot = 1'b0;
      sda_pull = 1'b0;
    end else if (!scl_prev && scl) begin
      // Rising SCL, sample
      if (ack_slot) begin
        if (mstate == M_RDATA && !sda_pull) begin // Own address ACK is not the master's
          if (sda) begin
            mstate = M_IDLE;          // Master NACK ends the read
          end else begin
            tx  = mem[ptr];           // Master wants another byte
            ptr = ptr + 8'd1;
          end
        end
      end else if (mstate != M_IDLE) begin
        shreg   = {shreg[6:0], sda};
        bit_cnt = bit_cnt + 1;
      end
    end else if (scl_prev && !scl) begin
      // Falling SCL, drive
      if (ack_slot) begin
        ack_slot = 1'b0;
        bit_cnt  = 0;
        sda_pull = (mstate == M_RDATA) && !tx[7]; // First data bit of a read
      end else if (bit_cnt == 8) begin
        ack_slot = 1'b1;
        sda_pull = 1'b0;
        case (mstate)
          M_ADDR: begin
            if (shreg[7:1] == DEV_ADDR && !nack_all) begin
              sda_pull = 1'b1;
              if (shreg[0]) begin
                mstate = M_RDATA;
                tx     = mem[ptr];
                ptr    = ptr + 8'd1;
              end else begin
                mstate = M_REG;
              end
            end else begin
              mstate = M_IDLE;        // Not us, or refused
            end
          end
          M_REG: begin
            if (!nack_all) begin
              ptr      = shreg;
              sda_pull = 1'b1;
              mstate   = M_WDATA;
            end else begin
              mstate = M_IDLE;
            end
          end
          M_WDATA: begin
            if (!nack_all) begin
              mem[ptr] = shreg;
              ptr      = ptr + 8'd1;  // Auto increment
              sda_pull = 1'b1;
            end else begin
              mstate = M_IDLE;
            end
          end
          default: sda_pull = 1'b0;  // M_RDATA, master answers
        endcase
      end else if (mstate == M_RDATA) begin
        sda_pull = !tx[7 - bit_cnt]; // MSB first
      end
    end
    scl_prev = scl;
    sda_prev = sda;
  end

endmodule
